// ==== rtl/ecc_blind_params.svh ====
`ifndef ECC_BLIND_PARAMS_SVH
`define ECC_BLIND_PARAMS_SVH

// ----------------------------------------------------------------------
// operand and digit sizes
// ----------------------------------------------------------------------
// scalar and group order width
`define ECC_REG_SIZE 384
// blinding random width, half the order length
`define ECC_RND_SIZE 192
// digit width, same as the bus word
`define ECC_RADIX 32

// P-384 group order n, upper half then lower half
`define ECC_GROUP_ORDER {192'hffffffffffffffffffffffffffffffffffffffffffffffff, \
                         192'hc7634d81f4372ddf581a0db248b0a77aecec196accc52973}

// ----------------------------------------------------------------------
// bus word counts
// ----------------------------------------------------------------------
// scalar words
`define ECC_SCALAR_WORDS 12
// random value words
`define ECC_RND_WORDS 6
// blinded result words, scalar plus random width
`define ECC_RESULT_WORDS 18

`endif

// ==== rtl/ecc_blind_pkg.sv ====
`include "ecc_blind_params.svh"

package ecc_blind_pkg;

    // ------------------------------------------------------------------
    // datapath types
    // ------------------------------------------------------------------
    // one radix digit, also one bus word
    typedef logic [`ECC_RADIX-1:0] digit_t;

    // secret scalar, expected below the group order
    typedef logic [`ECC_REG_SIZE-1:0] scalar_t;

    // blinding random, supplied from outside
    typedef logic [`ECC_RND_SIZE-1:0] rnd_t;

    // scalar + rnd * n, never wider than this
    typedef logic [`ECC_REG_SIZE+`ECC_RND_SIZE-1:0] blinded_t;

    // ------------------------------------------------------------------
    // control types
    // ------------------------------------------------------------------
    // result word index for the reader
    typedef logic [$clog2(`ECC_RESULT_WORDS)-1:0] word_cnt_t;

endpackage

// ==== rtl/ecc_blind_load.sv ====
`include "ecc_blind_params.svh"

module ecc_blind_load (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    scalar_wr_i,
    input  logic                    rnd_wr_i,
    input  logic                    start_i,
    input  ecc_blind_pkg::digit_t   wr_word_i,
    input  logic                    core_busy_i,
    output logic                    en_o,
    output ecc_blind_pkg::scalar_t  scalar_o,
    output ecc_blind_pkg::rnd_t     rnd_o,
    output logic                    pending_o
);

    import ecc_blind_pkg::*;

    // top bit of each shift register
    localparam int SCALAR_MSB = `ECC_SCALAR_WORDS * `ECC_RADIX - 1;
    localparam int RND_MSB    = `ECC_RND_WORDS * `ECC_RADIX - 1;

    scalar_t scalar_q;
    rnd_t    rnd_q;
    logic    en_q;
    logic    start_ok;

    // ------------------------------------------------------------------
    // operand shift registers
    // ------------------------------------------------------------------
    // new word enters at the top, shifts right
    // after a full load the first word sits in the lowest slot
    // extra writes drop the oldest word off the bottom
    always_ff @(posedge clk) begin
        if (scalar_wr_i) begin
            scalar_q <= {wr_word_i, scalar_q[SCALAR_MSB:`ECC_RADIX]};
        end
        if (rnd_wr_i) begin
            rnd_q <= {wr_word_i, rnd_q[RND_MSB:`ECC_RADIX]};
        end
    end

    // ------------------------------------------------------------------
    // start handling
    // ------------------------------------------------------------------
    // ignore start while a job runs or en is still in flight
    assign start_ok = start_i & ~core_busy_i & ~en_q;

    // registered start, one cycle wide
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= start_ok;
        end
    end

    assign en_o = en_q;

    // en cycle is the gap before core busy rises
    assign pending_o = en_q;

    // core copies these on en, later writes stage the next job
    assign scalar_o = scalar_q;
    assign rnd_o    = rnd_q;

endmodule

// ==== rtl/ecc_scalar_blinding.sv ====
`include "ecc_blind_params.svh"

module ecc_scalar_blinding (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    en_i,
    input  ecc_blind_pkg::scalar_t  data_i,
    input  ecc_blind_pkg::rnd_t     rnd_i,
    output ecc_blind_pkg::blinded_t data_o,
    output logic                    busy_o
);

    import ecc_blind_pkg::*;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int RADIX = `ECC_RADIX;
    // order digits plus one zero digit
    localparam int REG_DIG = ((`ECC_REG_SIZE + RADIX - 1) / RADIX) + 1;
    // random digits plus one zero digit
    localparam int RND_DIG = ((`ECC_RND_SIZE + RADIX - 1) / RADIX) + 1;
    // product digit span, last index doubles as done
    localparam int FULL_DIG = REG_DIG + RND_DIG;
    // digits handed out on data_o
    localparam int RES_DIG = (`ECC_REG_SIZE + `ECC_RND_SIZE) / RADIX;

    localparam int P_W = $clog2(FULL_DIG + 1);
    localparam int B_W = $clog2(RND_DIG + 1);
    localparam int A_W = $clog2(REG_DIG);

    // group order, zero extended to the digit array
    localparam logic [REG_DIG*RADIX-1:0] ORDER_EXT = (REG_DIG*RADIX)'(`ECC_GROUP_ORDER);

    // ------------------------------------------------------------------
    // operand digit arrays
    // ------------------------------------------------------------------
    digit_t a_dig      [REG_DIG];
    digit_t b_dig      [RND_DIG];
    digit_t scalar_dig [FULL_DIG];
    digit_t res_dig    [RES_DIG];

    logic [RND_DIG*RADIX-1:0]  rnd_ext;
    logic [FULL_DIG*RADIX-1:0] scalar_ext;

    // schoolbook indices
    logic [P_W-1:0] product_idx;
    logic [B_W-1:0] operand_idx;
    logic [B_W-1:0] op_start;
    logic [A_W-1:0] a_idx;

    // multiply-accumulate path
    logic [2*RADIX-1:0] mult_out;
    logic [3*RADIX-1:0] accu_q;
    logic [3*RADIX-1:0] accu_sum;

    // scalar add path
    digit_t add1_sum;
    logic   add1_cout;
    logic   carry_q;

    logic shift_state;
    logic more_terms;
    logic mult_done;

    assign rnd_ext    = (RND_DIG*RADIX)'(rnd_i);
    assign scalar_ext = (FULL_DIG*RADIX)'(data_i);

    // operands copied on en only
    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int i = 0; i < REG_DIG; i++) begin
                a_dig[i] <= ORDER_EXT[i*RADIX +: RADIX];
            end
            for (int j = 0; j < RND_DIG; j++) begin
                b_dig[j] <= rnd_ext[j*RADIX +: RADIX];
            end
            for (int k = 0; k < FULL_DIG; k++) begin
                scalar_dig[k] <= scalar_ext[k*RADIX +: RADIX];
            end
        end
    end

    // ------------------------------------------------------------------
    // arithmetic
    // ------------------------------------------------------------------
    // order digit paired with the current rnd digit
    assign a_idx = A_W'(product_idx - P_W'(operand_idx));

    // full 64-bit digit product
    assign mult_out = (2*RADIX)'(a_dig[a_idx]) * (2*RADIX)'(b_dig[operand_idx]);

    // three digits of headroom, no overflow for 7 terms plus carry
    assign accu_sum = accu_q + (3*RADIX)'(mult_out);

    // low accumulator digit + scalar digit + ripple carry
    assign {add1_cout, add1_sum} = (RADIX+1)'(accu_q[RADIX-1:0])
                                 + (RADIX+1)'(scalar_dig[product_idx])
                                 + (RADIX+1)'(carry_q);

    // ------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------
    assign mult_done = (product_idx == P_W'(FULL_DIG - 1));

    // another pair left in this column
    assign more_terms = (P_W'(operand_idx) < product_idx) &&
                        (operand_idx < B_W'(RND_DIG - 1));

    // first rnd digit of the next column, keeps a_idx inside the order
    assign op_start = (product_idx < P_W'(REG_DIG - 1)) ? '0 :
                      B_W'(product_idx - P_W'(REG_DIG - 2));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // idle in done state
            product_idx <= P_W'(FULL_DIG - 1);
            operand_idx <= '0;
            shift_state <= 1'b0;
            carry_q     <= 1'b0;
        end else if (en_i) begin
            product_idx <= '0;
            operand_idx <= '0;
            shift_state <= 1'b0;
            carry_q     <= 1'b0;
        end else if (!mult_done) begin
            if (shift_state) begin
                // column finished, move on
                product_idx <= product_idx + 1'b1;
                operand_idx <= op_start;
                carry_q     <= add1_cout;
                shift_state <= 1'b0;
            end else if (more_terms) begin
                operand_idx <= operand_idx + 1'b1;
            end else begin
                // last term of the column goes in this cycle
                shift_state <= 1'b1;
            end
        end
    end

    // accumulate on mac cycles, drop one digit on shift cycles
    always_ff @(posedge clk) begin
        if (en_i) begin
            accu_q <= '0;
        end else if (!mult_done) begin
            if (shift_state) begin
                accu_q <= {digit_t'(0), accu_q[3*RADIX-1:RADIX]};
            end else begin
                accu_q <= accu_sum;
            end
        end
    end

    // ------------------------------------------------------------------
    // result digits
    // ------------------------------------------------------------------
    // digit k written on the shift cycle of column k
    always_ff @(posedge clk) begin
        if (!mult_done && shift_state && (product_idx < P_W'(RES_DIG))) begin
            res_dig[product_idx] <= add1_sum;
        end
    end

    always_comb begin
        for (int i = 0; i < RES_DIG; i++) begin
            data_o[i*RADIX +: RADIX] = res_dig[i];
        end
    end

    assign busy_o = ~mult_done;

endmodule

// ==== rtl/ecc_blind_unload.sv ====
`include "ecc_blind_params.svh"

module ecc_blind_unload (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    core_busy_i,
    input  ecc_blind_pkg::blinded_t result_i,
    input  logic                    res_rd_i,
    output logic                    res_valid_o,
    output ecc_blind_pkg::digit_t   res_word_o
);

    import ecc_blind_pkg::*;

    localparam int RES_WORDS = `ECC_RESULT_WORDS;
    localparam int RADIX     = `ECC_RADIX;

    digit_t    hold_q [RES_WORDS];
    word_cnt_t rd_cnt_q;
    logic      busy_q;
    logic      fall_q;
    logic      valid_q;

    // ------------------------------------------------------------------
    // completion detect
    // ------------------------------------------------------------------
    // fall seen one cycle late, capture one more cycle later
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            busy_q <= core_busy_i;
            fall_q <= busy_q & ~core_busy_i;
        end
    end

    // result words held until overwritten
    always_ff @(posedge clk) begin
        if (fall_q) begin
            for (int i = 0; i < RES_WORDS; i++) begin
                hold_q[i] <= result_i[i*RADIX +: RADIX];
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_cnt_q <= '0;
            valid_q  <= 1'b0;
        end else if (fall_q) begin
            // new result wins over an unread one
            rd_cnt_q <= '0;
            valid_q  <= 1'b1;
        end else if (res_rd_i && valid_q) begin
            if (rd_cnt_q == word_cnt_t'(RES_WORDS - 1)) begin
                rd_cnt_q <= '0;
                valid_q  <= 1'b0;
            end else begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
        end
    end

    assign res_valid_o = valid_q;
    // lowest word first
    assign res_word_o  = hold_q[rd_cnt_q];

endmodule

// ==== rtl/ecc_blind_top.sv ====
module ecc_blind_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  scalar_wr_i,
    input  logic                  rnd_wr_i,
    input  logic                  start_i,
    input  logic                  res_rd_i,
    input  ecc_blind_pkg::digit_t wr_word_i,
    output logic                  busy_o,
    output logic                  res_valid_o,
    output ecc_blind_pkg::digit_t res_word_o
);

    import ecc_blind_pkg::*;

    // loader to core
    logic     core_en;
    scalar_t  core_scalar;
    rnd_t     core_rnd;
    logic     load_pending;

    // core to reader
    logic     core_busy;
    blinded_t core_result;

    // ------------------------------------------------------------------
    // operand loader
    // ------------------------------------------------------------------
    ecc_blind_load u_load (
        .clk         (clk),
        .reset_n     (reset_n),
        .scalar_wr_i (scalar_wr_i),
        .rnd_wr_i    (rnd_wr_i),
        .start_i     (start_i),
        .wr_word_i   (wr_word_i),
        .core_busy_i (core_busy),
        .en_o        (core_en),
        .scalar_o    (core_scalar),
        .rnd_o       (core_rnd),
        .pending_o   (load_pending)
    );

    // ------------------------------------------------------------------
    // blinding core
    // ------------------------------------------------------------------
    ecc_scalar_blinding u_core (
        .clk     (clk),
        .reset_n (reset_n),
        .en_i    (core_en),
        .data_i  (core_scalar),
        .rnd_i   (core_rnd),
        .data_o  (core_result),
        .busy_o  (core_busy)
    );

    // ------------------------------------------------------------------
    // result reader
    // ------------------------------------------------------------------
    ecc_blind_unload u_unload (
        .clk         (clk),
        .reset_n     (reset_n),
        .core_busy_i (core_busy),
        .result_i    (core_result),
        .res_rd_i    (res_rd_i),
        .res_valid_o (res_valid_o),
        .res_word_o  (res_word_o)
    );

    // busy from the start pulse onward, no gap at the handover
    assign busy_o = load_pending | core_busy;

endmodule

// ==== bench/tb_ecc_blind.sv ====
`include "ecc_blind_params.svh"

module tb_ecc_blind;

    timeunit 1ns;
    timeprecision 1ps;

    import ecc_blind_pkg::*;

    localparam string STIM_FILE = "bench/ecc_blind_stimulus.txt";

    // DUT ports
    logic   clk = 1'b0;
    logic   reset_n;
    logic   scalar_wr_i;
    logic   rnd_wr_i;
    logic   start_i;
    logic   res_rd_i;
    digit_t wr_word_i;
    logic   busy_o;
    logic   res_valid_o;
    digit_t res_word_o;

    // vectors from the stimulus file
    scalar_t  vec_scalar [$];
    rnd_t     vec_rnd    [$];
    blinded_t vec_exp    [$];

    integer seed;
    int     cycle_cnt   = 0;
    int     cycle_limit = 200;

    ecc_blind_top u_ecc_blind_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .scalar_wr_i (scalar_wr_i),
        .rnd_wr_i    (rnd_wr_i),
        .start_i     (start_i),
        .res_rd_i    (res_rd_i),
        .wr_word_i   (wr_word_i),
        .busy_o      (busy_o),
        .res_valid_o (res_valid_o),
        .res_word_o  (res_word_o)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: result never arrived");
            $display("*** FAILED ***");
            $fatal(1, "cycle limit of %0d reached", cycle_limit);
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic check_word(input digit_t got, input digit_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "flag mismatch");
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic load_vectors();
        int       fd;
        int       n;
        string    line;
        scalar_t  s;
        rnd_t     r;
        blinded_t e;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            $display("*** FAILED ***");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) != 0) begin
            // skip comment lines
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h", s, r, e);
                if (n == 3) begin
                    vec_scalar.push_back(s);
                    vec_rnd.push_back(r);
                    vec_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
        if (vec_exp.size() == 0) begin
            $display("the stimulus file holds no vectors");
            $display("*** FAILED ***");
            $fatal(1, "empty stimulus");
        end
    endtask

    // 0..3 idle cycles between bus operations
    task automatic idle_gap();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(negedge clk);
    endtask

    // lowest word first on both shift registers
    task automatic write_operands(input scalar_t s, input rnd_t r);
        for (int i = 0; i < `ECC_SCALAR_WORDS; i++) begin
            idle_gap();
            wr_word_i   = s[i*`ECC_RADIX +: `ECC_RADIX];
            scalar_wr_i = 1'b1;
            @(negedge clk);
            scalar_wr_i = 1'b0;
        end
        for (int i = 0; i < `ECC_RND_WORDS; i++) begin
            idle_gap();
            wr_word_i = r[i*`ECC_RADIX +: `ECC_RADIX];
            rnd_wr_i  = 1'b1;
            @(negedge clk);
            rnd_wr_i  = 1'b0;
        end
    endtask

    // busy one cycle after the start pulse
    task automatic start_job();
        check_flag(busy_o, 1'b0, "busy_o before start");
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        check_flag(busy_o, 1'b1, "busy_o one cycle after start");
    endtask

    // a start during busy must not restart with the staged operands
    task automatic stray_start();
        if (busy_o) begin
            start_i = 1'b1;
            @(negedge clk);
            start_i = 1'b0;
        end
    endtask

    task automatic wait_result();
        while (!res_valid_o) begin
            @(negedge clk);
        end
        check_flag(busy_o, 1'b0, "busy_o while res_valid_o high");
    endtask

    task automatic read_result(input blinded_t exp, input int v);
        for (int i = 0; i < `ECC_RESULT_WORDS; i++) begin
            idle_gap();
            check_flag(res_valid_o, 1'b1, $sformatf("res_valid_o before read %0d", i));
            check_word(res_word_o, exp[i*`ECC_RADIX +: `ECC_RADIX],
                       $sformatf("vector %0d word %0d", v, i));
            res_rd_i = 1'b1;
            @(negedge clk);
            res_rd_i = 1'b0;
        end
        check_flag(res_valid_o, 1'b0, "res_valid_o after the last read");
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        seed        = 85;
        reset_n     = 1'b0;
        scalar_wr_i = 1'b0;
        rnd_wr_i    = 1'b0;
        start_i     = 1'b0;
        res_rd_i    = 1'b0;
        wr_word_i   = '0;
        load_vectors();
        // writes, core run and reads fit well inside 400 cycles
        cycle_limit = vec_exp.size() * 400 + 200;

        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(res_valid_o, 1'b0, "res_valid_o after reset");

        write_operands(vec_scalar[0], vec_rnd[0]);
        for (int v = 0; v < vec_exp.size(); v++) begin
            start_job();
            // stage the next job under the running one
            if (v + 1 < vec_exp.size()) begin
                write_operands(vec_scalar[v+1], vec_rnd[v+1]);
            end
            stray_start();
            wait_result();
            read_result(vec_exp[v], v);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== bench/ecc_blind_stimulus.txt ====
# one vector per line: scalar (384 bit), random (192 bit), expected scalar + random * order
# all hex, most significant digit first
0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52972 ffffffffffffffffffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52972ffffffffffffffffffffffffffffffffffffffffffffffff
000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 000000000000000000000000000000000000000000000001 000000000000000000000000000000000000000000000000ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52973
ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52972 000000000000000000000000000000000000000000000001 0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000001ffffffffffffffffffffffffffffffffffffffffffffffff8ec69b03e86e5bbeb0341b6491614ef5d9d832d5998a52e5
000000000000000000000000000000000000000000000000000000000000000000000000000000000000000012345678 000000000000000000000000000000000000000100000001 000000000000000000000000000000000000000100000000ffffffffffffffffffffffffffffffffffffffffc7634d81bb9a7b614c513b91a0cab52d359cc0e5b9b142dddef97feb
0000000000000000000000000000000000000000000000000fedcba9876543210fedcba98765432100f1e2d3c4b5a697 100000000000000000000000000000000000000000000000 0ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52973fedcba9876543210fedcba98765432100f1e2d3c4b5a697
000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 000000000000000000000000000000000000000000000000 000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000cafef00d 000000000000000000000000000000000000000100000000 0000000000000000000000000000000000000000ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52973cafef00d

// ==== build.f ====
+incdir+rtl
rtl/ecc_blind_pkg.sv
rtl/ecc_blind_load.sv
rtl/ecc_scalar_blinding.sv
rtl/ecc_blind_unload.sv
rtl/ecc_blind_top.sv
bench/tb_ecc_blind.sv

// ==== Makefile ====
# Verilator flow for the scalar blinding testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := tb_ecc_blind
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
